// File: l2_channels.f
+incdir+rtl
rtl/l2_addr_pkg.sv
rtl/l2_msg_pkg.sv
rtl/l2_skid_buffer.sv
rtl/l2_replay_latch.sv
rtl/l2_inbound_stage.sv
rtl/l2_channels.sv
test/tb_l2_channels.sv

// File: Bender.yml
package:
  name: l2_channels

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/l2_addr_pkg.sv
      - rtl/l2_msg_pkg.sv
      - rtl/l2_skid_buffer.sv
      - rtl/l2_replay_latch.sv
      - rtl/l2_inbound_stage.sv
      - rtl/l2_channels.sv

  - target: test
    files:
      - test/tb_l2_channels.sv

// File: test/tb_l2_channels.sv
/* L2 channel front end testbench */

`timescale 1ns/10ps

module tb_l2_channels;

    import l2_addr_pkg::*;
    import l2_msg_pkg::*;

    localparam int WAIT_LIMIT = 20;
    localparam int OUT_MSGS   = 40;

    logic       clk;
    logic       rst;
    logic       cpu_req_valid_i, cpu_req_ready_o, cpu_req_valid_o, cpu_req_ready_i;
    cpu_req_t   cpu_req_i, cpu_req_o;
    logic       set_cpu_req_conflict_i, set_cpu_req_from_conflict_i;
    addr_t      cpu_req_addr_o;
    logic       fwd_in_valid_i, fwd_in_ready_o, fwd_in_valid_o, fwd_in_ready_i;
    fwd_in_t    fwd_in_i, fwd_in_o;
    logic       set_fwd_in_stalled_i, set_fwd_in_from_stalled_i;
    line_addr_t fwd_in_addr_o;
    logic       rsp_in_valid_i, rsp_in_ready_o, rsp_in_valid_o, rsp_in_ready_i;
    rsp_in_t    rsp_in_i, rsp_in_o;
    line_addr_t rsp_in_addr_o;
    logic       flush_valid_i, flush_ready_o, flush_i, flush_valid_o, flush_ready_i;
    logic       is_flush_all_o;
    logic       req_out_valid_i, req_out_ready_o, req_out_valid_o, req_out_ready_i;
    req_out_t   req_out_i, req_out_o;
    logic       rsp_out_valid_i, rsp_out_ready_o, rsp_out_valid_o, rsp_out_ready_i;
    rsp_out_t   rsp_out_i, rsp_out_o;
    logic [31:0] lfsr_q;

    l2_channels dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step for every bit taken
    function automatic logic [191:0] rand_bits(input int n);
        logic [191:0] v;
        int           i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v[i] = lfsr_q[0];
            lfsr_q = lfsr_step(lfsr_q);
        end
        return v;
    endfunction

    function automatic cpu_req_t rand_cpu_req();
        logic [191:0] raw;
        raw = rand_bits($bits(cpu_req_t));
        return raw[$bits(cpu_req_t)-1:0];
    endfunction

    function automatic fwd_in_t rand_fwd_in();
        logic [191:0] raw;
        raw = rand_bits($bits(fwd_in_t));
        return raw[$bits(fwd_in_t)-1:0];
    endfunction

    function automatic rsp_in_t rand_rsp_in();
        logic [191:0] raw;
        raw = rand_bits($bits(rsp_in_t));
        return raw[$bits(rsp_in_t)-1:0];
    endfunction

    function automatic req_out_t rand_req_out();
        logic [191:0] raw;
        raw = rand_bits($bits(req_out_t));
        return raw[$bits(req_out_t)-1:0];
    endfunction

    function automatic rsp_out_t rand_rsp_out();
        logic [191:0] raw;
        raw = rand_bits($bits(rsp_out_t));
        return raw[$bits(rsp_out_t)-1:0];
    endfunction

    task automatic fail_run();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [191:0] got,
                               input logic [191:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic next_slot();
        @(posedge clk);
        #10;
    endtask

    function automatic logic ready_of(input int ch);
        case (ch)
            0: return cpu_req_ready_o;
            1: return fwd_in_ready_o;
            default: return flush_ready_o;
        endcase
    endfunction

    // Returns in the drive slot right after the transfer edge
    task automatic wait_transfer(input int ch, input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!ready_of(ch)) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("%s stayed low for %0d cycles", name, WAIT_LIMIT);
                fail_run();
            end
            @(negedge clk);
        end
        next_slot();
    endtask

    task automatic send_cpu_req(input cpu_req_t m);
        cpu_req_i = m;
        cpu_req_valid_i = 1'b1;
        wait_transfer(0, "cpu_req_ready_o");
        cpu_req_valid_i = 1'b0;
    endtask

    task automatic send_fwd_in(input fwd_in_t m);
        fwd_in_i = m;
        fwd_in_valid_i = 1'b1;
        wait_transfer(1, "fwd_in_ready_o");
        fwd_in_valid_i = 1'b0;
    endtask

    task automatic send_flush(input logic all);
        flush_i = all;
        flush_valid_i = 1'b1;
        wait_transfer(3, "flush_ready_o");
        flush_valid_i = 1'b0;
    endtask

    task automatic test_reset_state();
        check_value("is_flush_all_o", is_flush_all_o, 1);
        check_value("cpu_req_valid_o", cpu_req_valid_o, 0);
        check_value("fwd_in_valid_o", fwd_in_valid_o, 0);
        check_value("rsp_in_valid_o", rsp_in_valid_o, 0);
        check_value("flush_valid_o", flush_valid_o, 0);
        check_value("req_out_valid_o", req_out_valid_o, 0);
        check_value("rsp_out_valid_o", rsp_out_valid_o, 0);
        check_value("cpu_req_ready_o", cpu_req_ready_o, 1);
        check_value("fwd_in_ready_o", fwd_in_ready_o, 1);
        check_value("rsp_in_ready_o", rsp_in_ready_o, 1);
        check_value("flush_ready_o", flush_ready_o, 1);
        check_value("req_out_ready_o", req_out_ready_o, 1);
        check_value("rsp_out_ready_o", rsp_out_ready_o, 1);
        check_value("cpu_req_o", cpu_req_o, 0);
        check_value("fwd_in_o", fwd_in_o, 0);
        check_value("rsp_in_o", rsp_in_o, 0);
    endtask

    task automatic test_cpu_req_path();
        cpu_req_t a;
        cpu_req_t b;
        a = rand_cpu_req();
        cpu_req_ready_i = 1'b1;
        cpu_req_i = a;
        cpu_req_valid_i = 1'b1;
        @(negedge clk);
        check_value("cpu_req_addr_o", cpu_req_addr_o, a.addr);
        check_value("cpu_req_ready_o", cpu_req_ready_o, 1);
        next_slot();
        cpu_req_valid_i = 1'b0;
        check_value("cpu_req_o", cpu_req_o, a);
        // Core stalled so the first request skids and the second waits outside
        a = rand_cpu_req();
        b = rand_cpu_req();
        cpu_req_ready_i = 1'b0;
        send_cpu_req(a);
        cpu_req_i = b;
        cpu_req_valid_i = 1'b1;
        @(negedge clk);
        check_value("cpu_req_ready_o", cpu_req_ready_o, 0);
        check_value("cpu_req_valid_o", cpu_req_valid_o, 1);
        check_value("cpu_req_addr_o", cpu_req_addr_o, a.addr);
        next_slot();
        cpu_req_ready_i = 1'b1;
        next_slot();
        check_value("cpu_req_o", cpu_req_o, a);
        wait_transfer(0, "cpu_req_ready_o");
        cpu_req_valid_i = 1'b0;
        check_value("cpu_req_o", cpu_req_o, b);
    endtask

    task automatic test_cpu_replay();
        cpu_req_t a;
        cpu_req_t b;
        a = rand_cpu_req();
        b = rand_cpu_req();
        send_cpu_req(a);
        set_cpu_req_conflict_i = 1'b1;
        next_slot();
        set_cpu_req_conflict_i = 1'b0;
        send_cpu_req(b);
        check_value("cpu_req_o", cpu_req_o, b);
        set_cpu_req_from_conflict_i = 1'b1;
        @(negedge clk);
        check_value("cpu_req_addr_o", cpu_req_addr_o, a.addr);
        next_slot();
        set_cpu_req_from_conflict_i = 1'b0;
        check_value("cpu_req_o", cpu_req_o, a);
    endtask

    task automatic test_fwd_replay();
        fwd_in_t a;
        fwd_in_t b;
        a = rand_fwd_in();
        b = rand_fwd_in();
        fwd_in_ready_i = 1'b1;
        send_fwd_in(a);
        check_value("fwd_in_o", fwd_in_o, a);
        set_fwd_in_stalled_i = 1'b1;
        next_slot();
        set_fwd_in_stalled_i = 1'b0;
        send_fwd_in(b);
        check_value("fwd_in_o", fwd_in_o, b);
        set_fwd_in_from_stalled_i = 1'b1;
        @(negedge clk);
        check_value("fwd_in_addr_o", fwd_in_addr_o, a.addr);
        next_slot();
        set_fwd_in_from_stalled_i = 1'b0;
        check_value("fwd_in_o", fwd_in_o, a);
    endtask

    task automatic test_rsp_and_flush();
        rsp_in_t r;
        r = rand_rsp_in();
        rsp_in_ready_i = 1'b1;
        rsp_in_i = r;
        rsp_in_valid_i = 1'b1;
        @(negedge clk);
        check_value("rsp_in_addr_o", rsp_in_addr_o, r.addr);
        check_value("rsp_in_ready_o", rsp_in_ready_o, 1);
        next_slot();
        rsp_in_valid_i = 1'b0;
        check_value("rsp_in_o", rsp_in_o, r);
        flush_ready_i = 1'b1;
        send_flush(1'b0);
        check_value("is_flush_all_o", is_flush_all_o, 0);
        send_flush(1'b1);
        check_value("is_flush_all_o", is_flush_all_o, 1);
    endtask

    // Both outbound channels run at once against a random outside ready
    task automatic test_outbound();
        req_out_t req_q[$];
        rsp_out_t rsp_q[$];
        req_out_t req_hold;
        rsp_out_t rsp_hold;
        logic     req_stall, rsp_stall, req_fire, rsp_fire;
        int       req_sent, req_got, rsp_sent, rsp_got, cycles;
        req_stall = 1'b0;
        rsp_stall = 1'b0;
        req_got = 0;
        rsp_got = 0;
        cycles = 0;
        req_out_i = rand_req_out();
        rsp_out_i = rand_rsp_out();
        req_out_valid_i = 1'b1;
        rsp_out_valid_i = 1'b1;
        req_sent = 1;
        rsp_sent = 1;
        req_out_ready_i = rand_bits(1) != 0;
        rsp_out_ready_i = rand_bits(1) != 0;
        while (req_got < OUT_MSGS || rsp_got < OUT_MSGS) begin
            cycles++;
            if (cycles > 20 * OUT_MSGS) begin
                $display("outbound messages did not all arrive in time");
                fail_run();
            end
            @(negedge clk);
            if (req_stall) begin
                check_value("req_out_valid_o", req_out_valid_o, 1);
                check_value("req_out_o", req_out_o, req_hold);
            end
            if (rsp_stall) begin
                check_value("rsp_out_valid_o", rsp_out_valid_o, 1);
                check_value("rsp_out_o", rsp_out_o, rsp_hold);
            end
            req_fire = req_out_valid_i && req_out_ready_o;
            rsp_fire = rsp_out_valid_i && rsp_out_ready_o;
            if (req_fire) req_q.push_back(req_out_i);
            if (rsp_fire) rsp_q.push_back(rsp_out_i);
            if (req_out_valid_o && req_out_ready_i) begin
                if (req_q.size() == 0) begin
                    $display("req_out delivered a message that was never sent");
                    fail_run();
                end
                check_value("req_out_o", req_out_o, req_q.pop_front());
                req_got++;
            end
            if (rsp_out_valid_o && rsp_out_ready_i) begin
                if (rsp_q.size() == 0) begin
                    $display("rsp_out delivered a message that was never sent");
                    fail_run();
                end
                check_value("rsp_out_o", rsp_out_o, rsp_q.pop_front());
                rsp_got++;
            end
            req_stall = req_out_valid_o && !req_out_ready_i;
            rsp_stall = rsp_out_valid_o && !rsp_out_ready_i;
            req_hold = req_out_o;
            rsp_hold = rsp_out_o;
            next_slot();
            if (req_fire) begin
                req_out_valid_i = req_sent < OUT_MSGS;
                req_out_i = rand_req_out();
                req_sent++;
            end
            if (rsp_fire) begin
                rsp_out_valid_i = rsp_sent < OUT_MSGS;
                rsp_out_i = rand_rsp_out();
                rsp_sent++;
            end
            req_out_ready_i = rand_bits(1) != 0;
            rsp_out_ready_i = rand_bits(1) != 0;
        end
        @(negedge clk);
        check_value("req_out_valid_o", req_out_valid_o, 0);
        check_value("rsp_out_valid_o", rsp_out_valid_o, 0);
    endtask

    initial begin
        lfsr_q = 32'h54afa4dd;
        rst = 1'b0;
        {cpu_req_valid_i, cpu_req_ready_i, set_cpu_req_conflict_i} = '0;
        set_cpu_req_from_conflict_i = 1'b0;
        {fwd_in_valid_i, fwd_in_ready_i, set_fwd_in_stalled_i} = '0;
        set_fwd_in_from_stalled_i = 1'b0;
        {rsp_in_valid_i, rsp_in_ready_i, flush_valid_i, flush_i, flush_ready_i} = '0;
        {req_out_valid_i, req_out_ready_i, rsp_out_valid_i, rsp_out_ready_i} = '0;
        cpu_req_i = '0;
        fwd_in_i = '0;
        rsp_in_i = '0;
        req_out_i = '0;
        rsp_out_i = '0;
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b1;
        next_slot();
        test_reset_state();
        test_cpu_req_path();
        test_cpu_replay();
        test_fwd_replay();
        test_rsp_and_flush();
        test_outbound();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: rtl/l2_channels.sv
/* L2 cache channel front end */

`timescale 1ns/10ps

module l2_channels (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    cpu_req_valid_i,
    output logic                    cpu_req_ready_o,
    input  l2_msg_pkg::cpu_req_t    cpu_req_i,
    output logic                    cpu_req_valid_o,
    input  logic                    cpu_req_ready_i,
    output l2_msg_pkg::cpu_req_t    cpu_req_o,
    input  logic                    set_cpu_req_conflict_i,
    input  logic                    set_cpu_req_from_conflict_i,
    output l2_addr_pkg::addr_t      cpu_req_addr_o,

    input  logic                    fwd_in_valid_i,
    output logic                    fwd_in_ready_o,
    input  l2_msg_pkg::fwd_in_t     fwd_in_i,
    output logic                    fwd_in_valid_o,
    input  logic                    fwd_in_ready_i,
    output l2_msg_pkg::fwd_in_t     fwd_in_o,
    input  logic                    set_fwd_in_stalled_i,
    input  logic                    set_fwd_in_from_stalled_i,
    output l2_addr_pkg::line_addr_t fwd_in_addr_o,

    input  logic                    rsp_in_valid_i,
    output logic                    rsp_in_ready_o,
    input  l2_msg_pkg::rsp_in_t     rsp_in_i,
    output logic                    rsp_in_valid_o,
    input  logic                    rsp_in_ready_i,
    output l2_msg_pkg::rsp_in_t     rsp_in_o,
    output l2_addr_pkg::line_addr_t rsp_in_addr_o,

    input  logic                    flush_valid_i,
    output logic                    flush_ready_o,
    input  logic                    flush_i,
    output logic                    flush_valid_o,
    input  logic                    flush_ready_i,
    output logic                    is_flush_all_o,

    input  logic                    req_out_valid_i,
    output logic                    req_out_ready_o,
    input  l2_msg_pkg::req_out_t    req_out_i,
    output logic                    req_out_valid_o,
    input  logic                    req_out_ready_i,
    output l2_msg_pkg::req_out_t    req_out_o,

    input  logic                    rsp_out_valid_i,
    output logic                    rsp_out_ready_o,
    input  l2_msg_pkg::rsp_out_t    rsp_out_i,
    output logic                    rsp_out_valid_o,
    input  logic                    rsp_out_ready_i,
    output l2_msg_pkg::rsp_out_t    rsp_out_o
);

    import l2_msg_pkg::*;

    // Network and CPU into the controller
    l2_inbound_stage u_inbound (
        .clk                         (clk),
        .rst                         (rst),
        .cpu_req_valid_i             (cpu_req_valid_i),
        .cpu_req_ready_o             (cpu_req_ready_o),
        .cpu_req_i                   (cpu_req_i),
        .cpu_req_valid_o             (cpu_req_valid_o),
        .cpu_req_ready_i             (cpu_req_ready_i),
        .cpu_req_o                   (cpu_req_o),
        .set_cpu_req_conflict_i      (set_cpu_req_conflict_i),
        .set_cpu_req_from_conflict_i (set_cpu_req_from_conflict_i),
        .cpu_req_addr_o              (cpu_req_addr_o),
        .fwd_in_valid_i              (fwd_in_valid_i),
        .fwd_in_ready_o              (fwd_in_ready_o),
        .fwd_in_i                    (fwd_in_i),
        .fwd_in_valid_o              (fwd_in_valid_o),
        .fwd_in_ready_i              (fwd_in_ready_i),
        .fwd_in_o                    (fwd_in_o),
        .set_fwd_in_stalled_i        (set_fwd_in_stalled_i),
        .set_fwd_in_from_stalled_i   (set_fwd_in_from_stalled_i),
        .fwd_in_addr_o               (fwd_in_addr_o),
        .rsp_in_valid_i              (rsp_in_valid_i),
        .rsp_in_ready_o              (rsp_in_ready_o),
        .rsp_in_i                    (rsp_in_i),
        .rsp_in_valid_o              (rsp_in_valid_o),
        .rsp_in_ready_i              (rsp_in_ready_i),
        .rsp_in_o                    (rsp_in_o),
        .rsp_in_addr_o               (rsp_in_addr_o),
        .flush_valid_i               (flush_valid_i),
        .flush_ready_o               (flush_ready_o),
        .flush_i                     (flush_i),
        .flush_valid_o               (flush_valid_o),
        .flush_ready_i               (flush_ready_i),
        .is_flush_all_o              (is_flush_all_o)
    );

    // Coherence requests to the network
    l2_skid_buffer #(.payload_t(req_out_t)) u_req_out_skid (
        .clk     (clk),
        .rst     (rst),
        .valid_i (req_out_valid_i),
        .ready_o (req_out_ready_o),
        .data_i  (req_out_i),
        .valid_o (req_out_valid_o),
        .ready_i (req_out_ready_i),
        .data_o  (req_out_o)
    );

    // Coherence responses to the network
    l2_skid_buffer #(.payload_t(rsp_out_t)) u_rsp_out_skid (
        .clk     (clk),
        .rst     (rst),
        .valid_i (rsp_out_valid_i),
        .ready_o (rsp_out_ready_o),
        .data_i  (rsp_out_i),
        .valid_o (rsp_out_valid_o),
        .ready_i (rsp_out_ready_i),
        .data_o  (rsp_out_o)
    );

endmodule

// File: rtl/l2_inbound_stage.sv
/* L2 inbound channel stage */

`timescale 1ns/10ps

module l2_inbound_stage (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    cpu_req_valid_i,
    output logic                    cpu_req_ready_o,
    input  l2_msg_pkg::cpu_req_t    cpu_req_i,
    output logic                    cpu_req_valid_o,
    input  logic                    cpu_req_ready_i,
    output l2_msg_pkg::cpu_req_t    cpu_req_o,
    input  logic                    set_cpu_req_conflict_i,
    input  logic                    set_cpu_req_from_conflict_i,
    output l2_addr_pkg::addr_t      cpu_req_addr_o,

    input  logic                    fwd_in_valid_i,
    output logic                    fwd_in_ready_o,
    input  l2_msg_pkg::fwd_in_t     fwd_in_i,
    output logic                    fwd_in_valid_o,
    input  logic                    fwd_in_ready_i,
    output l2_msg_pkg::fwd_in_t     fwd_in_o,
    input  logic                    set_fwd_in_stalled_i,
    input  logic                    set_fwd_in_from_stalled_i,
    output l2_addr_pkg::line_addr_t fwd_in_addr_o,

    input  logic                    rsp_in_valid_i,
    output logic                    rsp_in_ready_o,
    input  l2_msg_pkg::rsp_in_t     rsp_in_i,
    output logic                    rsp_in_valid_o,
    input  logic                    rsp_in_ready_i,
    output l2_msg_pkg::rsp_in_t     rsp_in_o,
    output l2_addr_pkg::line_addr_t rsp_in_addr_o,

    input  logic                    flush_valid_i,
    output logic                    flush_ready_o,
    input  logic                    flush_i,
    output logic                    flush_valid_o,
    input  logic                    flush_ready_i,
    output logic                    is_flush_all_o
);

    import l2_msg_pkg::*;

    cpu_req_t cpu_req_skid;
    cpu_req_t cpu_req_look;
    fwd_in_t  fwd_in_skid;
    fwd_in_t  fwd_in_look;
    rsp_in_t  rsp_in_skid;
    rsp_in_t  rsp_in_q;
    logic     flush_skid;
    logic     is_flush_all_q;

    // CPU requests
    l2_skid_buffer #(.payload_t(cpu_req_t)) u_cpu_req_skid (
        .clk     (clk),
        .rst     (rst),
        .valid_i (cpu_req_valid_i),
        .ready_o (cpu_req_ready_o),
        .data_i  (cpu_req_i),
        .valid_o (cpu_req_valid_o),
        .ready_i (cpu_req_ready_i),
        .data_o  (cpu_req_skid)
    );

    l2_replay_latch #(.msg_t(cpu_req_t)) u_cpu_req_latch (
        .clk         (clk),
        .rst         (rst),
        .load_i      (cpu_req_valid_o && cpu_req_ready_i),
        .save_i      (set_cpu_req_conflict_i),
        .replay_i    (set_cpu_req_from_conflict_i),
        .next_i      (cpu_req_skid),
        .msg_o       (cpu_req_o),
        .lookahead_o (cpu_req_look)
    );

    assign cpu_req_addr_o = cpu_req_look.addr;

    // Forwards
    l2_skid_buffer #(.payload_t(fwd_in_t)) u_fwd_in_skid (
        .clk     (clk),
        .rst     (rst),
        .valid_i (fwd_in_valid_i),
        .ready_o (fwd_in_ready_o),
        .data_i  (fwd_in_i),
        .valid_o (fwd_in_valid_o),
        .ready_i (fwd_in_ready_i),
        .data_o  (fwd_in_skid)
    );

    l2_replay_latch #(.msg_t(fwd_in_t)) u_fwd_in_latch (
        .clk         (clk),
        .rst         (rst),
        .load_i      (fwd_in_valid_o && fwd_in_ready_i),
        .save_i      (set_fwd_in_stalled_i),
        .replay_i    (set_fwd_in_from_stalled_i),
        .next_i      (fwd_in_skid),
        .msg_o       (fwd_in_o),
        .lookahead_o (fwd_in_look)
    );

    assign fwd_in_addr_o = fwd_in_look.addr;

    // Responses
    l2_skid_buffer #(.payload_t(rsp_in_t)) u_rsp_in_skid (
        .clk     (clk),
        .rst     (rst),
        .valid_i (rsp_in_valid_i),
        .ready_o (rsp_in_ready_o),
        .data_i  (rsp_in_i),
        .valid_o (rsp_in_valid_o),
        .ready_i (rsp_in_ready_i),
        .data_o  (rsp_in_skid)
    );

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rsp_in_q <= '0;
        end else if (rsp_in_valid_o && rsp_in_ready_i) begin
            rsp_in_q <= rsp_in_skid;
        end
    end

    assign rsp_in_o      = rsp_in_q;
    assign rsp_in_addr_o = rsp_in_skid.addr;

    // Flush requests
    l2_skid_buffer #(.payload_t(logic)) u_flush_skid (
        .clk     (clk),
        .rst     (rst),
        .valid_i (flush_valid_i),
        .ready_o (flush_ready_o),
        .data_i  (flush_i),
        .valid_o (flush_valid_o),
        .ready_i (flush_ready_i),
        .data_o  (flush_skid)
    );

    // Full flush until told otherwise
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            is_flush_all_q <= 1'b1;
        end else if (flush_valid_o && flush_ready_i) begin
            is_flush_all_q <= flush_skid;
        end
    end

    assign is_flush_all_o = is_flush_all_q;

endmodule

// File: rtl/l2_replay_latch.sv
/* Message register with replay copy */

`timescale 1ns/10ps

module l2_replay_latch #(
    parameter type msg_t = l2_msg_pkg::cpu_req_t
) (
    input  logic clk,
    input  logic rst,
    input  logic load_i,
    input  logic save_i,
    input  logic replay_i,
    input  msg_t next_i,
    output msg_t msg_o,
    output msg_t lookahead_o
);

    msg_t msg_q;
    msg_t saved_q;

    // Replay wins over a fresh load
    assign lookahead_o = replay_i ? saved_q : next_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            msg_q <= '0;
        end else if (replay_i || load_i) begin
            msg_q <= lookahead_o;
        end
    end

    // Copy of the message that has to wait
    always_ff @(posedge clk) begin
        if (save_i) begin
            saved_q <= msg_q;
        end
    end

    assign msg_o = msg_q;

endmodule

// File: rtl/l2_skid_buffer.sv
/* Bypassable one-entry skid buffer */

`timescale 1ns/10ps

module l2_skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    logic     full_q;
    logic     fill;
    payload_t held_q;

    // Accepted but the downstream side is stalled
    assign fill = valid_i && !full_q && !ready_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            full_q <= 1'b0;
        end else if (ready_i) begin
            full_q <= 1'b0;
        end else if (fill) begin
            full_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            held_q <= data_i;
        end
    end

    // Upstream ready only looks at the local full flag
    assign ready_o = !full_q;

    assign valid_o = valid_i || full_q;
    assign data_o  = full_q ? held_q : data_i;

endmodule

// File: rtl/l2_msg_pkg.sv
/* L2 message encodings and channel structs */

`include "l2_chan_cfg.svh"

package l2_msg_pkg;

    import l2_addr_pkg::*;

    typedef logic [1:0] cpu_msg_t;
    typedef logic [4:0] coh_msg_t;
    typedef logic [2:0] hsize_t;
    typedef logic [5:0] amo_t;
    typedef logic [`L2_REQ_ID_BITS-1:0] req_id_t;
    typedef logic [`L2_INVACK_BITS-1:0] invack_cnt_t;

    // CPU request kinds
    localparam cpu_msg_t CPU_READ       = 2'b00;
    localparam cpu_msg_t CPU_READ_ATOM  = 2'b01;
    localparam cpu_msg_t CPU_WRITE      = 2'b10;
    localparam cpu_msg_t CPU_WRITE_ATOM = 2'b11;

    // Access sizes
    localparam hsize_t HSIZE_B  = 3'b000;
    localparam hsize_t HSIZE_HW = 3'b001;
    localparam hsize_t HSIZE_W  = 3'b010;
    localparam hsize_t HSIZE_DW = 3'b011;

    // Requests to the directory
    localparam coh_msg_t REQ_GETS = 5'd0;
    localparam coh_msg_t REQ_GETM = 5'd1;
    localparam coh_msg_t REQ_PUTS = 5'd2;
    localparam coh_msg_t REQ_PUTM = 5'd3;

    // Forwards from the directory
    localparam coh_msg_t FWD_GETS   = 5'd8;
    localparam coh_msg_t FWD_GETM   = 5'd9;
    localparam coh_msg_t FWD_INV    = 5'd10;
    localparam coh_msg_t FWD_PUTACK = 5'd11;

    // Responses
    localparam coh_msg_t RSP_DATA   = 5'd16;
    localparam coh_msg_t RSP_EDATA  = 5'd17;
    localparam coh_msg_t RSP_INVACK = 5'd18;

    typedef struct packed {
        cpu_msg_t cpu_msg;
        hsize_t   hsize;
        logic     hprot;
        addr_t    addr;
        word_t    word;
        amo_t     amo;
        logic     aq;
        logic     rl;
    } cpu_req_t;

    typedef struct packed {
        coh_msg_t   coh_msg;
        line_addr_t addr;
        req_id_t    req_id;
        line_t      line;
        word_mask_t word_mask;
    } fwd_in_t;

    typedef struct packed {
        coh_msg_t    coh_msg;
        line_addr_t  addr;
        line_t       line;
        word_mask_t  word_mask;
        invack_cnt_t invack_cnt;
    } rsp_in_t;

    typedef struct packed {
        coh_msg_t   coh_msg;
        logic       hprot;
        line_addr_t addr;
        line_t      line;
        word_mask_t word_mask;
    } req_out_t;

    typedef struct packed {
        coh_msg_t   coh_msg;
        req_id_t    req_id;
        logic       to_req;
        line_addr_t addr;
        line_t      line;
        word_mask_t word_mask;
    } rsp_out_t;

endpackage

// File: rtl/l2_addr_pkg.sv
/* L2 address and data types */

`include "l2_chan_cfg.svh"

package l2_addr_pkg;

    // Full byte address
    typedef logic [`L2_ADDR_BITS-1:0] addr_t;

    // Address with the line offset stripped
    typedef logic [`L2_ADDR_BITS-`L2_OFFSET_BITS-1:0] line_addr_t;

    typedef logic [`L2_WORD_BITS-1:0] word_t;

    typedef logic [`L2_WORDS_PER_LINE*`L2_WORD_BITS-1:0] line_t;

    // One bit per word of a line
    typedef logic [`L2_WORDS_PER_LINE-1:0] word_mask_t;

endpackage

// File: rtl/l2_chan_cfg.svh
/* L2 channel widths */

`ifndef L2_CHAN_CFG_SVH
`define L2_CHAN_CFG_SVH

// Byte address and line offset
`define L2_ADDR_BITS 32
`define L2_OFFSET_BITS 4

// Data words and line size in words
`define L2_WORD_BITS 64
`define L2_WORDS_PER_LINE 2

// Requester id of a forwarded request
`define L2_REQ_ID_BITS 4

// Invalidate-ack count carried by responses
`define L2_INVACK_BITS 4

`endif
